// File: Bender.yml
package:
  name: gba_io

sources:
  - include_dirs:
      - design
    files:
      - design/gba_bus_pkg.sv
      - design/gba_io_pkg.sv
      - design/io_reg_file.sv
      - design/timer_unit.sv
      - design/interrupt_controller.sv
      - design/led_controller.sv
      - design/gba_io_top.sv
  - target: test
    include_dirs:
      - design
      - testbench
    files:
      - testbench/tb_gba_io_top.sv

// File: compile.f
+incdir+design
+incdir+testbench
design/gba_bus_pkg.sv
design/gba_io_pkg.sv
design/io_reg_file.sv
design/timer_unit.sv
design/interrupt_controller.sv
design/led_controller.sv
design/gba_io_top.sv
testbench/tb_gba_io_top.sv

// File: design/gba_bus_pkg.sv
`include "gba_io_macros.svh"

package gba_bus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // CPU side request, one outstanding at a time
    typedef struct packed {
        bus_op_e               op;
        logic [`IO_ADDR_W-1:0] addr;
        logic [`IO_DATA_W-1:0] wdata;
    } bus_req_t;

    // Unmapped index or KEYINPUT write sets err
    typedef struct packed {
        logic [`IO_DATA_W-1:0] rdata;
        logic                  err;
    } bus_resp_t;

endpackage: gba_bus_pkg

// File: design/gba_io_macros.svh
`ifndef GBA_IO_MACROS_SVH
`define GBA_IO_MACROS_SVH

// Register data and index widths
`define IO_DATA_W 16
`define IO_ADDR_W 5

`define NUM_TIMERS 4
`define NUM_LED_REGS 4

// IE/IF width, timer 0 sits at bit 3
`define IRQ_W 14
`define IRQ_TIMER_BASE 3

`endif

// File: design/gba_io_pkg.sv
`include "gba_io_macros.svh"

package gba_io_pkg;

    typedef enum logic [`IO_ADDR_W-1:0] {
        REG_TM0CNT_L = 5'd0,
        REG_TM0CNT_H = 5'd1,
        REG_TM1CNT_L = 5'd2,
        REG_TM1CNT_H = 5'd3,
        REG_TM2CNT_L = 5'd4,
        REG_TM2CNT_H = 5'd5,
        REG_TM3CNT_L = 5'd6,
        REG_TM3CNT_H = 5'd7,
        REG_KEYINPUT = 5'd8,
        REG_IE       = 5'd9,
        REG_IF       = 5'd10,
        REG_IME      = 5'd11,
        REG_LED0     = 5'd12,
        REG_LED1     = 5'd13,
        REG_LED2     = 5'd14,
        REG_LED3     = 5'd15
    } io_reg_e;

    typedef enum logic [1:0] {
        PRE_1    = 2'd0,
        PRE_64   = 2'd1,
        PRE_256  = 2'd2,
        PRE_1024 = 2'd3
    } tm_prescale_e;

    // TMxCNT_H bits 1:0, 2, 6 and 7
    typedef struct packed {
        tm_prescale_e prescale;
        logic         cascade;
        logic         irq_en;
        logic         start;
    } tm_ctrl_t;

endpackage: gba_io_pkg

// File: design/gba_io_top.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"
`default_nettype none

module gba_io_top (
    input  logic                   gba_clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  gba_bus_pkg::bus_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output gba_bus_pkg::bus_resp_t resp,
    input  logic [`IO_DATA_W-1:0]  buttons,
    input  logic [7:0]             led_sel,
    output logic [7:0]             led,
    output logic                   irq_n);

    import gba_io_pkg::*;

    tm_ctrl_t               tm_ctrl [`NUM_TIMERS];
    logic [`IO_DATA_W-1:0]  tm_reload [`NUM_TIMERS];
    logic [`IO_DATA_W-1:0]  tm_count [`NUM_TIMERS];
    logic [`NUM_TIMERS-1:0] tm_ovf;
    logic [`NUM_TIMERS-1:0] tm_irq_en;
    logic [`IRQ_W-1:0]      ie;
    logic [`IRQ_W-1:0]      reg_if;
    logic [`IRQ_W-1:0]      if_ack;
    logic                   ime;
    logic [`IO_DATA_W-1:0]  led_regs [`NUM_LED_REGS];

    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : g_irq_en
        assign tm_irq_en[i] = tm_ctrl[i].irq_en;
    end

    io_reg_file u_io_reg_file (.gba_clk, .arst_n, .req_valid, .req_ready, .req,
                               .resp_valid, .resp_ready, .resp, .buttons,
                               .tm_count, .reg_if, .tm_ctrl, .tm_reload,
                               .ie, .ime, .if_ack, .led_regs);

    timer_unit u_timer_unit (.gba_clk, .arst_n, .tm_ctrl, .tm_reload,
                             .tm_count, .tm_ovf);

    interrupt_controller u_interrupt_controller (.gba_clk, .arst_n, .tm_ovf,
                                                 .tm_irq_en, .ie, .ime, .if_ack,
                                                 .reg_if, .irq_n);

    // Debug byte for the board LEDs
    led_controller u_led_controller (.led_sel, .led_regs, .buttons, .led);

endmodule: gba_io_top

`default_nettype wire

// File: design/interrupt_controller.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"
`default_nettype none

module interrupt_controller (
    input  logic                   gba_clk,
    input  logic                   arst_n,
    input  logic [`NUM_TIMERS-1:0] tm_ovf,
    input  logic [`NUM_TIMERS-1:0] tm_irq_en,
    input  logic [`IRQ_W-1:0]      ie,
    input  logic                   ime,
    input  logic [`IRQ_W-1:0]      if_ack,
    output logic [`IRQ_W-1:0]      reg_if,
    output logic                   irq_n);

    logic [`IRQ_W-1:0] if_set;

    // Timer events land at their IF positions
    always_comb begin
        if_set = '0;
        if_set[`IRQ_TIMER_BASE +: `NUM_TIMERS] = tm_ovf & tm_irq_en;
    end

    always_ff @(posedge gba_clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_if <= '0;
        end else begin
            // A new event beats a clear in the same cycle
            reg_if <= (reg_if & ~if_ack) | if_set;
        end
    end

    always_ff @(posedge gba_clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= !(ime && |(ie & reg_if));
        end
    end

    // A clear held longer would swallow events that follow it
    a_ack_pulse: assert property (@(posedge gba_clk) disable iff (!arst_n)
        |if_ack |=> if_ack == '0);

endmodule: interrupt_controller

`default_nettype wire

// File: design/io_reg_file.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"
`default_nettype none

module io_reg_file (
    input  logic                   gba_clk,
    input  logic                   arst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  gba_bus_pkg::bus_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output gba_bus_pkg::bus_resp_t resp,
    input  logic [`IO_DATA_W-1:0]  buttons,
    input  logic [`IO_DATA_W-1:0]  tm_count [`NUM_TIMERS],
    input  logic [`IRQ_W-1:0]      reg_if,
    output gba_io_pkg::tm_ctrl_t   tm_ctrl [`NUM_TIMERS],
    output logic [`IO_DATA_W-1:0]  tm_reload [`NUM_TIMERS],
    output logic [`IRQ_W-1:0]      ie,
    output logic                   ime,
    output logic [`IRQ_W-1:0]      if_ack,
    output logic [`IO_DATA_W-1:0]  led_regs [`NUM_LED_REGS]);

    import gba_bus_pkg::*;
    import gba_io_pkg::*;

    logic                  accept;
    logic                  wr_en;
    io_reg_e               reg_idx;
    logic [1:0]            tm_sel;
    logic [1:0]            led_idx;
    logic [`IO_DATA_W-1:0] rd_data;
    logic                  rd_err;

    function automatic tm_ctrl_t word_to_ctrl(input logic [`IO_DATA_W-1:0] w);
        tm_ctrl_t c;
        c.prescale = tm_prescale_e'(w[1:0]);
        c.cascade  = w[2];
        c.irq_en   = w[6];
        c.start    = w[7];
        return c;
    endfunction

    function automatic logic [`IO_DATA_W-1:0] ctrl_to_word(input tm_ctrl_t c);
        return {8'h00, c.start, c.irq_en, 3'b000, c.cascade, c.prescale};
    endfunction

    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign wr_en     = accept && (req.op == OP_WRITE);
    assign reg_idx   = io_reg_e'(req.addr);
    assign tm_sel    = req.addr[2:1];
    assign led_idx   = req.addr[1:0];

    // Read mux, sampled on the accept edge
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (reg_idx)
            REG_TM0CNT_L, REG_TM1CNT_L, REG_TM2CNT_L, REG_TM3CNT_L:
                rd_data = tm_count[tm_sel];
            REG_TM0CNT_H, REG_TM1CNT_H, REG_TM2CNT_H, REG_TM3CNT_H:
                rd_data = ctrl_to_word(tm_ctrl[tm_sel]);
            REG_KEYINPUT: begin
                rd_data = buttons;
                rd_err  = (req.op == OP_WRITE);
            end
            REG_IE:  rd_data = `IO_DATA_W'(ie);
            REG_IF:  rd_data = `IO_DATA_W'(reg_if);
            REG_IME: rd_data = `IO_DATA_W'(ime);
            REG_LED0, REG_LED1, REG_LED2, REG_LED3:
                rd_data = led_regs[led_idx];
            default: rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge gba_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_TIMERS; i++) begin
                tm_ctrl[i] <= '0;
            end
            for (int i = 0; i < `NUM_LED_REGS; i++) begin
                led_regs[i] <= '0;
            end
            ie     <= '0;
            ime    <= 1'b0;
            if_ack <= '0;
        end else begin
            // Acknowledge lasts one cycle only
            if_ack <= '0;
            if (wr_en) begin
                case (reg_idx)
                    REG_TM0CNT_H, REG_TM1CNT_H, REG_TM2CNT_H, REG_TM3CNT_H:
                        tm_ctrl[tm_sel] <= word_to_ctrl(req.wdata);
                    REG_IE:  ie     <= req.wdata[`IRQ_W-1:0];
                    REG_IF:  if_ack <= req.wdata[`IRQ_W-1:0];
                    REG_IME: ime    <= req.wdata[0];
                    REG_LED0, REG_LED1, REG_LED2, REG_LED3:
                        led_regs[led_idx] <= req.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Reload values, used by the timers on start
    always_ff @(posedge gba_clk) begin
        if (wr_en && (reg_idx inside {REG_TM0CNT_L, REG_TM1CNT_L,
                                      REG_TM2CNT_L, REG_TM3CNT_L})) begin
            tm_reload[tm_sel] <= req.wdata;
        end
    end

    always_ff @(posedge gba_clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge gba_clk) begin
        if (accept) begin
            resp.rdata <= (req.op == OP_READ) ? rd_data : '0;
            resp.err   <= rd_err;
        end
    end

    a_resp_held: assert property (@(posedge gba_clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

    // One response per request, gone once taken
    a_one_in_flight: assert property (@(posedge gba_clk) disable iff (!arst_n)
        resp_valid && resp_ready |=> !resp_valid);

endmodule: io_reg_file

`default_nettype wire

// File: design/led_controller.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"
`default_nettype none

module led_controller (
    input  logic [7:0]            led_sel,
    input  logic [`IO_DATA_W-1:0] led_regs [`NUM_LED_REGS],
    input  logic [`IO_DATA_W-1:0] buttons,
    output logic [7:0]            led);

    always_comb begin
        case (led_sel)
            8'h0: led = led_regs[0][7:0];
            8'h1: led = led_regs[0][15:8];
            8'h2: led = led_regs[1][7:0];
            8'h3: led = led_regs[1][15:8];
            8'h4: led = led_regs[2][7:0];
            8'h5: led = led_regs[2][15:8];
            8'h6: led = led_regs[3][7:0];
            8'h7: led = led_regs[3][15:8];
            // Buttons are active low
            default: led = led_sel[7] ? ~buttons[15:8] : ~buttons[7:0];
        endcase
    end

endmodule: led_controller

`default_nettype wire

// File: design/timer_unit.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"
`default_nettype none

module timer_unit (
    input  logic                  gba_clk,
    input  logic                  arst_n,
    input  gba_io_pkg::tm_ctrl_t  tm_ctrl [`NUM_TIMERS],
    input  logic [`IO_DATA_W-1:0] tm_reload [`NUM_TIMERS],
    output logic [`IO_DATA_W-1:0] tm_count [`NUM_TIMERS],
    output logic [`NUM_TIMERS-1:0] tm_ovf);

    import gba_io_pkg::*;

    for (genvar i = 0; i < `NUM_TIMERS; i++) begin : g_timer
        logic [9:0] presc_cnt;
        logic       start_q;
        logic       tick;
        logic       inc_en;
        logic       start_rise;

        always_comb begin
            case (tm_ctrl[i].prescale)
                PRE_1:   tick = 1'b1;
                PRE_64:  tick = &presc_cnt[5:0];
                PRE_256: tick = &presc_cnt[7:0];
                default: tick = &presc_cnt;
            endcase
        end

        // Timer 0 has nothing below it to cascade from
        if (i == 0) begin : g_base
            assign inc_en = tick;
        end else begin : g_chain
            assign inc_en = tm_ctrl[i].cascade ? tm_ovf[i-1] : tick;
        end

        assign start_rise = tm_ctrl[i].start && !start_q;

        always_ff @(posedge gba_clk or negedge arst_n) begin
            if (!arst_n) begin
                presc_cnt   <= '0;
                start_q     <= 1'b0;
                tm_count[i] <= '0;
                tm_ovf[i]   <= 1'b0;
            end else begin
                presc_cnt <= presc_cnt + 10'd1;
                start_q   <= tm_ctrl[i].start;
                tm_ovf[i] <= 1'b0;
                if (start_rise) begin
                    tm_count[i] <= tm_reload[i];
                end else if (tm_ctrl[i].start && inc_en) begin
                    if (&tm_count[i]) begin
                        tm_count[i] <= tm_reload[i];
                        tm_ovf[i]   <= 1'b1;
                    end else begin
                        tm_count[i] <= tm_count[i] + 1'b1;
                    end
                end
            end
        end

        // Back-to-back pulses only when the reload itself is FFFF
        a_ovf_pulse: assert property (@(posedge gba_clk) disable iff (!arst_n)
            tm_ovf[i] && !(&tm_count[i]) |=> !tm_ovf[i]);
    end

endmodule: timer_unit

`default_nettype wire

// File: testbench/gba_io_model.svh
`ifndef GBA_IO_MODEL_SVH
`define GBA_IO_MODEL_SVH

// Register state as the bus master should see it
logic [`IRQ_W-1:0]     m_ie;
logic [`IRQ_W-1:0]     m_if;
logic                  m_ime;
logic [`IO_DATA_W-1:0] m_led [`NUM_LED_REGS];
logic [`IO_DATA_W-1:0] m_tm_h [`NUM_TIMERS];

task automatic model_clear();
    m_ie  = '0;
    m_if  = '0;
    m_ime = 1'b0;
    for (int i = 0; i < `NUM_LED_REGS; i++) begin
        m_led[i] = '0;
    end
    for (int i = 0; i < `NUM_TIMERS; i++) begin
        m_tm_h[i] = '0;
    end
endtask

function automatic bus_resp_t model_read(input logic [`IO_ADDR_W-1:0] addr,
                                         input logic [`IO_DATA_W-1:0] btn);
    bus_resp_t r;
    r = '0;
    case (addr)
        // Counts only read back while no timer has run
        5'd0, 5'd2, 5'd4, 5'd6: r.rdata = '0;
        5'd1, 5'd3, 5'd5, 5'd7: r.rdata = m_tm_h[addr[2:1]];
        5'd8:  r.rdata = btn;
        5'd9:  r.rdata = `IO_DATA_W'(m_ie);
        5'd10: r.rdata = `IO_DATA_W'(m_if);
        5'd11: r.rdata = `IO_DATA_W'(m_ime);
        5'd12, 5'd13, 5'd14, 5'd15: r.rdata = m_led[addr[1:0]];
        default: r.err = 1'b1;
    endcase
    return r;
endfunction

task automatic model_write(input logic [`IO_ADDR_W-1:0] addr,
                           input logic [`IO_DATA_W-1:0] wdata, output bus_resp_t r);
    r = '0;
    case (addr)
        5'd0, 5'd2, 5'd4, 5'd6: ;
        // Prescale, cascade, irq enable and start bits only
        5'd1, 5'd3, 5'd5, 5'd7: m_tm_h[addr[2:1]] = wdata & 16'h00C7;
        5'd8:  r.err = 1'b1;
        5'd9:  m_ie = wdata[`IRQ_W-1:0];
        5'd10: m_if = m_if & ~wdata[`IRQ_W-1:0];
        5'd11: m_ime = wdata[0];
        5'd12, 5'd13, 5'd14, 5'd15: m_led[addr[1:0]] = wdata;
        default: r.err = 1'b1;
    endcase
endtask

task automatic model_timer_event(input int t);
    m_if[`IRQ_TIMER_BASE + t] = 1'b1;
endtask

function automatic logic model_irq_n();
    return !(m_ime && |(m_ie & m_if));
endfunction

function automatic logic [7:0] model_led(input logic [7:0] sel,
                                         input logic [`IO_DATA_W-1:0] btn);
    logic [`IO_DATA_W-1:0] w;
    if (sel < 8'd8) begin
        w = m_led[sel[2:1]];
        return sel[0] ? w[15:8] : w[7:0];
    end
    return sel[7] ? ~btn[15:8] : ~btn[7:0];
endfunction

`endif

// File: testbench/tb_gba_io_top.sv
`timescale 1ns/1ns
`include "gba_io_macros.svh"

module tb_gba_io_top;

    import gba_bus_pkg::*;
    import gba_io_pkg::*;

    localparam int WAIT_LIMIT = 50;
    localparam int POLL_LIMIT = 40;

    logic                  gba_clk;
    logic                  arst_n;
    logic                  req_valid;
    logic                  req_ready;
    bus_req_t              req;
    logic                  resp_valid;
    logic                  resp_ready;
    bus_resp_t             resp;
    logic [`IO_DATA_W-1:0] buttons;
    logic [7:0]            led_sel;
    logic [7:0]            led;
    logic                  irq_n;

    integer seed;
    int     error_cnt;
    int     check_cnt;
    int     held_cnt;
    string  test_name;

    `include "gba_io_model.svh"

    gba_io_top u_gba_io_top (.gba_clk, .arst_n, .req_valid, .req_ready, .req,
                             .resp_valid, .resp_ready, .resp, .buttons,
                             .led_sel, .led, .irq_n);

    initial gba_clk = 1'b0;
    always #4 gba_clk = ~gba_clk;

    task automatic report_failure(input string what);
        error_cnt++;
        $display("Failure in %s: %s", test_name, what);
    endtask

    task automatic stop_on_timeout(input string what);
        error_cnt++;
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic check_resp(input bus_resp_t exp, input bus_resp_t got);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected rdata=%h err=%b, actual rdata=%h err=%b",
                     test_name, exp.rdata, exp.err, got.rdata, got.err);
        end
    endtask

    task automatic check_led(input logic [7:0] exp, input logic [7:0] got);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected led=%h, actual led=%h", test_name, exp, got);
        end
    endtask

    task automatic check_irq(input logic exp, input logic got);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected irq_n=%b, actual irq_n=%b", test_name, exp, got);
        end
    endtask

    // One request, one response, then irq_n after it settles
    task automatic bus_xfer(input bus_op_e op, input logic [`IO_ADDR_W-1:0] addr,
                            input logic [`IO_DATA_W-1:0] wdata, output bus_resp_t got);
        int        wait_cnt;
        logic      seen;
        logic      done;
        bus_resp_t first;
        @(negedge gba_clk);
        req_valid  = 1'b1;
        req.op     = op;
        req.addr   = addr;
        req.wdata  = wdata;
        wait_cnt   = 0;
        while (!req_ready) begin
            @(negedge gba_clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) stop_on_timeout("req_ready");
        end
        @(negedge gba_clk);
        req_valid = 1'b0;
        seen      = 1'b0;
        done      = 1'b0;
        first     = '0;
        wait_cnt  = 0;
        while (!done) begin
            if (resp_valid) begin
                if (!seen) begin
                    first = resp;
                    seen  = 1'b1;
                end else if (resp !== first) begin
                    report_failure("response changed while it was held");
                end
                if (req_ready) report_failure("req_ready high while a response is held");
            end
            resp_ready = ($random(seed) & 3) != 0;
            if (resp_valid && !resp_ready) held_cnt++;
            done = resp_valid && resp_ready;
            @(negedge gba_clk);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) stop_on_timeout("resp_valid");
        end
        resp_ready = 1'b0;
        got        = first;
        @(negedge gba_clk);
        check_irq(model_irq_n(), irq_n);
    endtask

    task automatic write_reg(input logic [`IO_ADDR_W-1:0] addr,
                             input logic [`IO_DATA_W-1:0] wdata);
        bus_resp_t exp;
        bus_resp_t got;
        model_write(addr, wdata, exp);
        bus_xfer(OP_WRITE, addr, wdata, got);
        check_resp(exp, got);
    endtask

    task automatic read_reg(input logic [`IO_ADDR_W-1:0] addr);
        bus_resp_t exp;
        bus_resp_t got;
        exp = model_read(addr, buttons);
        bus_xfer(OP_READ, addr, '0, got);
        check_resp(exp, got);
    endtask

    task automatic poll_if(input int idx);
        bus_resp_t got;
        int        polls;
        polls = 0;
        got   = '0;
        while (!got.rdata[idx]) begin
            if (polls == POLL_LIMIT) stop_on_timeout($sformatf("IF bit %0d", idx));
            bus_xfer(OP_READ, REG_IF, '0, got);
            polls++;
        end
    endtask

    initial begin
        logic [`IO_ADDR_W-1:0] a;
        logic [`IO_DATA_W-1:0] d;
        int                    t;
        seed       = 44472;
        error_cnt  = 0;
        check_cnt  = 0;
        held_cnt   = 0;
        arst_n     = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        buttons    = 16'hFFFF;
        led_sel    = 8'h00;
        model_clear();
        repeat (5) @(negedge gba_clk);
        arst_n = 1'b1;
        @(negedge gba_clk);

        test_name = "reset";
        if (!req_ready) report_failure("req_ready low after reset");
        if (resp_valid) report_failure("resp_valid high after reset");
        check_irq(1'b1, irq_n);
        for (int i = 0; i < 16; i++) read_reg(5'(i));

        // Timers stay stopped during random traffic
        test_name = "reg_rw";
        for (int i = 0; i < 200; i++) begin
            a = $random(seed);
            d = $random(seed);
            if (a < 5'd8 && a[0]) d[7] = 1'b0;
            buttons = $random(seed);
            if ($random(seed) & 1) write_reg(a, d);
            else read_reg(a);
        end
        for (int i = 0; i < 16; i++) read_reg(5'(i));

        test_name = "led_mux";
        for (int i = 0; i < 64; i++) begin
            @(negedge gba_clk);
            d       = $random(seed);
            buttons = $random(seed);
            led_sel = d[8] ? {5'd0, d[2:0]} : d[7:0];
            @(posedge gba_clk);
            check_led(model_led(led_sel, buttons), led);
        end

        test_name = "timer_irq";
        write_reg(REG_IE, '0);
        write_reg(REG_IME, '0);
        t = $random(seed) & 3;
        write_reg(5'(2 * t), 16'hFFF0);
        write_reg(5'(2 * t + 1), 16'h00C0);
        poll_if(`IRQ_TIMER_BASE + t);
        write_reg(5'(2 * t + 1), 16'h0040);
        model_timer_event(t);
        read_reg(REG_IF);
        write_reg(REG_IE, 16'(1 << (`IRQ_TIMER_BASE + t)));
        write_reg(REG_IME, 16'h0001);
        d = $random(seed);
        d[`IRQ_TIMER_BASE + t] = 1'b0;
        write_reg(REG_IF, d);
        read_reg(REG_IF);
        write_reg(REG_IF, 16'(1 << (`IRQ_TIMER_BASE + t)));
        read_reg(REG_IF);

        // Timer 1 counts timer 0 overflows
        test_name = "cascade";
        write_reg(REG_IME, '0);
        write_reg(REG_IE, '0);
        write_reg(REG_TM0CNT_L, 16'hFFFF);
        write_reg(REG_TM1CNT_L, 16'hFFFE);
        write_reg(REG_TM1CNT_H, 16'h00C4);
        write_reg(REG_TM0CNT_H, 16'h0080);
        poll_if(`IRQ_TIMER_BASE + 1);
        write_reg(REG_TM0CNT_H, '0);
        write_reg(REG_TM1CNT_H, 16'h0044);
        model_timer_event(1);
        read_reg(REG_IF);
        write_reg(REG_IF, 16'(1 << (`IRQ_TIMER_BASE + 1)));
        read_reg(REG_IF);

        test_name = "backpressure";
        if (held_cnt == 0) report_failure("no response was ever held");

        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule: tb_gba_io_top
